/* mac_init.f */
src/mac_init_pkg.sv
src/mac_regs_pkg.sv
src/reg_cmd_if.sv
src/init_sequencer.sv
src/cmd_fifo.sv
src/axil_cmd_master.sv
src/mac_init_top.sv
verif/mac_init_assertions.sv
verif/tb_mac_init.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mac_init -f mac_init.f -o sim_mac_init \
    && ./obj_dir/sim_mac_init > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

/* verif/tb_mac_init.sv */
module tb_mac_init;

    timeunit 1ns;
    timeprecision 1ps;

    import mac_init_pkg::*;
    import mac_regs_pkg::*;

    localparam int LINK_DOWN_READS  = 3;
    localparam int RESET_HOLD_READS = 2;
    // every command up to six transactions of three handshakes, 8 cycles each
    localparam int WATCHDOG_CYCLES  = WAIT_INIT_CYCLES + INIT_STEPS * 6 * 3 * 8;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        awvalid;
    axil_addr_t  awaddr;
    logic        awready = 1'b0;
    logic        wvalid;
    axil_data_t  wdata;
    logic [3:0]  wstrb;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic [1:0]  bresp = 2'b00;
    logic        bready;
    logic        arvalid;
    axil_addr_t  araddr;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    axil_data_t  rdata = '0;
    logic [1:0]  rresp = 2'b00;
    logic        rready;
    logic        mac_inited;

    axil_data_t  regs [256] = '{default: '0};
    int unsigned lcg_state = 97;
    int          status_reads = 0;
    int          hold_reads = 0;
    int          write_count = 0;
    int          read_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mac_init_top i_mac_init_top (.*);

    bind mac_init_top mac_init_assertions i_mac_init_assertions (.*);

    always #20 clk = ~clk;

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic int count_kind(cmd_kind_t kind);
        int n;
        n = 0;
        for (int i = 0; i < INIT_STEPS; i++)
        begin
            if (INIT_KIND[i] == kind)
            begin
                n++;
            end
        end
        return n;
    endfunction

    // reset bits that clear by themselves
    function automatic axil_data_t self_clear_bits(axil_addr_t addr);
        if (addr == PCS_CONTROL_ADDR)
        begin
            return PCS_RESET_BIT;
        end
        if (addr == COMMAND_CONFIG_ADDR)
        begin
            return MAC_RESET_BIT;
        end
        return '0;
    endfunction

    function automatic axil_data_t read_register(axil_addr_t addr);
        axil_data_t value;
        axil_data_t hold_bits;
        hold_bits = self_clear_bits(addr);
        value = regs[addr[9:2]];
        if (addr == PCS_STATUS_ADDR)
        begin
            value = (status_reads < LINK_DOWN_READS) ? 32'h0 : LINK_UP_BIT;
            status_reads++;
        end
        else if ((value & hold_bits) != '0)
        begin
            if (hold_reads < RESET_HOLD_READS)
            begin
                hold_reads++;
            end
            else
            begin
                value = value & ~hold_bits;
                regs[addr[9:2]] = value;
            end
        end
        return value;
    endfunction

    task automatic serve_write();
        int gap;
        gap = next_delay();
        repeat (gap) @(posedge clk);
        awready <= 1'b1;
        wready  <= 1'b1;
        @(posedge clk);
        awready <= 1'b0;
        wready  <= 1'b0;
        regs[awaddr[9:2]] = wdata;
        hold_reads = 0;
        write_count++;
        gap = next_delay();
        repeat (gap) @(posedge clk);
        bvalid <= 1'b1;
        @(posedge clk);
        bvalid <= 1'b0;
    endtask

    task automatic serve_read();
        int         gap;
        axil_data_t value;
        gap = next_delay();
        repeat (gap) @(posedge clk);
        arready <= 1'b1;
        @(posedge clk);
        arready <= 1'b0;
        value = read_register(araddr);
        read_count++;
        gap = next_delay();
        repeat (gap) @(posedge clk);
        rvalid <= 1'b1;
        rdata  <= value;
        @(posedge clk);
        rvalid <= 1'b0;
    endtask

    // slave model, one transaction at a time
    always
    begin
        @(posedge clk);
        if (!reset && awvalid && wvalid)
        begin
            serve_write();
        end
        else if (!reset && arvalid)
        begin
            serve_read();
        end
    end

    initial
    begin
        int cycles;
        int expected_writes;
        int expected_reads;
        expected_writes = count_kind(CMD_WRITE);
        expected_reads  = count_kind(CMD_POLL) + LINK_DOWN_READS + 2 * RESET_HOLD_READS;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!(awvalid || arvalid))
        begin
            @(posedge clk);
            cycles++;
        end
        tests_run++;
        $display("startup: first bus access %0d cycles after reset, at %0t", cycles, $time);

        while (write_count < expected_writes)
        begin
            @(posedge clk);
        end
        tests_run++;
        $display("configuration: %0d writes done at %0t", write_count, $time);

        while (!mac_inited)
        begin
            @(posedge clk);
        end
        tests_run++;
        $display("polling: mac_inited high after %0d reads, at %0t", read_count, $time);

        // quiet bus after init
        repeat (16) @(posedge clk);
        tests_run++;
        if (write_count != expected_writes || read_count != expected_reads)
        begin
            $display("FAILED at %0t: write_count %0d/%0d, read_count %0d/%0d (got/expected)",
                     $time, write_count, expected_writes, read_count, expected_reads);
            tests_failed++;
        end
        else if (!mac_inited)
        begin
            $display("completion: mac_inited fell after the init sequence");
            tests_failed++;
        end
        else if (i_mac_init_top.i_mac_init_assertions.failures != 0)
        begin
            $display("completion: %0d assertions failed during the run",
                     i_mac_init_top.i_mac_init_assertions.failures);
            tests_failed++;
        end
        else
        begin
            $display("completion: bus idle, mac_inited held at %0t", $time);
        end

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: init sequence not finished after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verif/mac_init_assertions.sv */
module mac_init_assertions
(
    input logic                     clk,
    input logic                     reset,
    input logic                     awvalid,
    input mac_init_pkg::axil_addr_t awaddr,
    input logic                     awready,
    input logic                     wvalid,
    input mac_init_pkg::axil_data_t wdata,
    input logic [3:0]               wstrb,
    input logic                     wready,
    input logic                     bvalid,
    input logic                     bready,
    input logic                     arvalid,
    input mac_init_pkg::axil_addr_t araddr,
    input logic                     arready,
    input logic                     rvalid,
    input mac_init_pkg::axil_data_t rdata,
    input logic                     rready,
    input logic                     mac_inited
);

    timeunit 1ns;
    timeprecision 1ps;

    import mac_init_pkg::*;
    import mac_regs_pkg::*;

    int   idle_cycles;
    int   step;
    int   cur;
    logic r_hit;
    int   failures = 0;

    // table entry the bus should be working on
    assign cur   = (step < INIT_STEPS) ? step : INIT_STEPS - 1;
    assign r_hit = ((rdata & INIT_MASK[cur]) == INIT_DATA[cur]);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            idle_cycles <= 0;
            step        <= 0;
        end
        else
        begin
            if (idle_cycles < WAIT_INIT_CYCLES)
            begin
                idle_cycles <= idle_cycles + 1;
            end
            if ((bvalid && bready) || (rvalid && rready && r_hit))
            begin
                step <= step + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (idle_cycles < WAIT_INIT_CYCLES)
            |-> (!(awvalid || wvalid || arvalid || bready || rready) && !mac_inited))
        else
        begin
            failures++;
            $error("bus activity during start-up delay");
        end

    assert property (@(posedge clk) disable iff (reset)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else
        begin
            failures++;
            $error("awvalid or awaddr changed before awready");
        end

    assert property (@(posedge clk) disable iff (reset)
        (wvalid && !wready) |=> (wvalid && $stable(wdata)))
        else
        begin
            failures++;
            $error("wvalid or wdata changed before wready");
        end

    assert property (@(posedge clk) disable iff (reset)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else
        begin
            failures++;
            $error("arvalid or araddr changed before arready");
        end

    // register writes are always full words
    assert property (@(posedge clk) disable iff (reset)
        wvalid |-> (wstrb == 4'b1111))
        else
        begin
            failures++;
            $error("wstrb not all ones during a write");
        end

    // writes follow the table in order
    assert property (@(posedge clk) disable iff (reset)
        (awvalid && awready) |-> (INIT_KIND[cur] == CMD_WRITE && awaddr == INIT_ADDR[cur]))
        else
        begin
            failures++;
            $error("aw address does not match table step %0d", cur);
        end

    assert property (@(posedge clk) disable iff (reset)
        (wvalid && wready) |-> (wdata == INIT_DATA[cur]))
        else
        begin
            failures++;
            $error("write data does not match table step %0d", cur);
        end

    assert property (@(posedge clk) disable iff (reset)
        (arvalid && arready) |-> (INIT_KIND[cur] == CMD_POLL && araddr == INIT_ADDR[cur]))
        else
        begin
            failures++;
            $error("ar address does not match table step %0d", cur);
        end

    // poll miss means a repeat read of the same register
    assert property (@(posedge clk) disable iff (reset)
        (rvalid && rready && !r_hit) |=> (arvalid && araddr == $past(araddr)))
        else
        begin
            failures++;
            $error("poll miss not followed by a repeat read");
        end

    assert property (@(posedge clk) disable iff (reset)
        $rose(mac_inited) |-> ($past(rvalid && rready) && $past(rdata[1:0]) == 2'b11
                               && step == INIT_STEPS))
        else
        begin
            failures++;
            $error("mac_inited rose without the final poll");
        end

    assert property (@(posedge clk) disable iff (reset)
        mac_inited |=> (mac_inited && !(awvalid || wvalid || arvalid)))
        else
        begin
            failures++;
            $error("mac_inited dropped or bus active after init");
        end

endmodule

/* src/mac_init_top.sv */
module mac_init_top
(
    input  logic                     clk,
    input  logic                     reset,
    output logic                     awvalid,
    output mac_init_pkg::axil_addr_t awaddr,
    input  logic                     awready,
    output logic                     wvalid,
    output mac_init_pkg::axil_data_t wdata,
    output logic [3:0]               wstrb,
    input  logic                     wready,
    input  logic                     bvalid,
    input  logic [1:0]               bresp,
    output logic                     bready,
    output logic                     arvalid,
    output mac_init_pkg::axil_addr_t araddr,
    input  logic                     arready,
    input  logic                     rvalid,
    input  mac_init_pkg::axil_data_t rdata,
    input  logic [1:0]               rresp,
    output logic                     rready,
    output logic                     mac_inited
);

    reg_cmd_if seq_to_fifo ();
    reg_cmd_if fifo_to_master ();

    init_sequencer i_init_sequencer
    (
        .clk   (clk),
        .reset (reset),
        .cmd   (seq_to_fifo.source)
    );

    cmd_fifo i_cmd_fifo
    (
        .clk   (clk),
        .reset (reset),
        .push  (seq_to_fifo.sink),
        .pop   (fifo_to_master.source)
    );

    axil_cmd_master i_axil_cmd_master
    (
        .clk        (clk),
        .reset      (reset),
        .cmd        (fifo_to_master.sink),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rready     (rready),
        .mac_inited (mac_inited)
    );

endmodule

/* src/axil_cmd_master.sv */
module axil_cmd_master
(
    input  logic                     clk,
    input  logic                     reset,
    reg_cmd_if.sink                  cmd,
    output logic                     awvalid,
    output mac_init_pkg::axil_addr_t awaddr,
    input  logic                     awready,
    output logic                     wvalid,
    output mac_init_pkg::axil_data_t wdata,
    output logic [3:0]               wstrb,
    input  logic                     wready,
    input  logic                     bvalid,
    input  logic [1:0]               bresp,
    output logic                     bready,
    output logic                     arvalid,
    output mac_init_pkg::axil_addr_t araddr,
    input  logic                     arready,
    input  logic                     rvalid,
    input  mac_init_pkg::axil_data_t rdata,
    input  logic [1:0]               rresp,
    output logic                     rready,
    output logic                     mac_inited
);

    import mac_init_pkg::*;

    logic       busy;
    logic       accept;
    logic       b_done;
    logic       r_done;
    logic       poll_hit;
    logic       cmd_done;
    logic       cur_last;
    axil_data_t cur_expect;
    axil_data_t cur_mask;

    // one command in flight, nothing taken after the last one
    assign cmd.ready = !busy && !mac_inited;
    assign accept    = cmd.valid && cmd.ready;
    assign b_done    = bvalid && bready;
    assign r_done    = rvalid && rready;
    assign poll_hit  = ((rdata & cur_mask) == cur_expect);
    assign cmd_done  = b_done || (r_done && poll_hit);
    assign wstrb     = 4'b1111;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            awaddr     <= cmd.addr;
            araddr     <= cmd.addr;
            wdata      <= cmd.data;
            cur_expect <= cmd.data;
            cur_mask   <= cmd.mask;
            cur_last   <= cmd.last;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            mac_inited <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                busy <= 1'b1;
                if (cmd.kind == CMD_WRITE)
                begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                    bready  <= 1'b1;
                end
                else
                begin
                    arvalid <= 1'b1;
                end
            end
            // aw and w may be accepted in either order
            if (awvalid && awready)
            begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready)
            begin
                wvalid <= 1'b0;
            end
            if (b_done)
            begin
                bready <= 1'b0;
            end
            if (arvalid && arready)
            begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (r_done)
            begin
                rready <= 1'b0;
                // poll miss, read the same register again
                if (!poll_hit)
                begin
                    arvalid <= 1'b1;
                end
            end
            if (cmd_done)
            begin
                busy <= 1'b0;
                if (cur_last)
                begin
                    mac_inited <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/cmd_fifo.sv */
module cmd_fifo
#(
    // power of two, pointers wrap naturally
    parameter int DEPTH = mac_init_pkg::CMD_FIFO_DEPTH
)
(
    input  logic      clk,
    input  logic      reset,
    reg_cmd_if.sink   push,
    reg_cmd_if.source pop
);

    import mac_init_pkg::*;

    cmd_kind_t                kind_mem [DEPTH];
    axil_addr_t               addr_mem [DEPTH];
    axil_data_t               data_mem [DEPTH];
    axil_data_t               mask_mem [DEPTH];
    logic                     last_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     do_push;
    logic                     do_pop;

    assign push.ready = (count != ($clog2(DEPTH) + 1)'(DEPTH));
    assign pop.valid  = (count != '0);
    assign do_push    = push.valid && push.ready;
    assign do_pop     = pop.valid && pop.ready;

    assign pop.kind = kind_mem[rd_ptr];
    assign pop.addr = addr_mem[rd_ptr];
    assign pop.data = data_mem[rd_ptr];
    assign pop.mask = mask_mem[rd_ptr];
    assign pop.last = last_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            kind_mem[wr_ptr] <= push.kind;
            addr_mem[wr_ptr] <= push.addr;
            data_mem[wr_ptr] <= push.data;
            mask_mem[wr_ptr] <= push.mask;
            last_mem[wr_ptr] <= push.last;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/init_sequencer.sv */
module init_sequencer
(
    input  logic      clk,
    input  logic      reset,
    reg_cmd_if.source cmd
);

    import mac_init_pkg::*;
    import mac_regs_pkg::*;

    seq_state_t                          state;
    logic [$clog2(WAIT_INIT_CYCLES)-1:0] delay_cnt;
    init_step_t                          step;
    logic                                last_step;

    assign last_step = (step == init_step_t'(INIT_STEPS - 1));

    // table entry of the current step
    assign cmd.valid = (state == S_ISSUE);
    assign cmd.kind  = INIT_KIND[step];
    assign cmd.addr  = INIT_ADDR[step];
    assign cmd.data  = INIT_DATA[step];
    assign cmd.mask  = INIT_MASK[step];
    assign cmd.last  = last_step;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state     <= S_WAIT_INIT;
            delay_cnt <= '0;
            step      <= '0;
        end
        else
        begin
            case (state)
                S_WAIT_INIT:
                begin
                    if (delay_cnt == $bits(delay_cnt)'(WAIT_INIT_CYCLES - 1))
                    begin
                        state <= S_ISSUE;
                    end
                    else
                    begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                S_ISSUE:
                begin
                    if (cmd.valid && cmd.ready)
                    begin
                        if (last_step)
                        begin
                            state <= S_DONE;
                        end
                        else
                        begin
                            step <= step + 1'b1;
                        end
                    end
                end
                // S_DONE holds until reset
                default:
                begin
                    state <= S_DONE;
                end
            endcase
        end
    end

endmodule

/* src/reg_cmd_if.sv */
interface reg_cmd_if;

    import mac_init_pkg::*;

    logic       valid;
    logic       ready;
    cmd_kind_t  kind;
    axil_addr_t addr;
    // write value or expected poll value
    axil_data_t data;
    axil_data_t mask;
    logic       last;

    modport source (output valid, kind, addr, data, mask, last, input ready);

    modport sink (input valid, kind, addr, data, mask, last, output ready);

    modport monitor (input valid, ready, kind, addr, data, mask, last);

endinterface

/* src/mac_regs_pkg.sv */
package mac_regs_pkg;

    import mac_init_pkg::*;

    // byte addresses, mac at word 0x00, pcs at word 0x80
    localparam axil_addr_t COMMAND_CONFIG_ADDR   = 32'h0000_0008;
    localparam axil_addr_t MAC_0_ADDR            = 32'h0000_000C;
    localparam axil_addr_t MAC_1_ADDR            = 32'h0000_0010;
    localparam axil_addr_t FRM_LENGTH_ADDR       = 32'h0000_0014;
    localparam axil_addr_t PAUSE_QUANT_ADDR      = 32'h0000_0018;
    localparam axil_addr_t RX_SECTION_EMPTY_ADDR = 32'h0000_001C;
    localparam axil_addr_t RX_SECTION_FULL_ADDR  = 32'h0000_0020;
    localparam axil_addr_t TX_SECTION_EMPTY_ADDR = 32'h0000_0024;
    localparam axil_addr_t TX_SECTION_FULL_ADDR  = 32'h0000_0028;
    localparam axil_addr_t RX_ALMOST_EMPTY_ADDR  = 32'h0000_002C;
    localparam axil_addr_t RX_ALMOST_FULL_ADDR   = 32'h0000_0030;
    localparam axil_addr_t TX_ALMOST_EMPTY_ADDR  = 32'h0000_0034;
    localparam axil_addr_t TX_ALMOST_FULL_ADDR   = 32'h0000_0038;
    localparam axil_addr_t TX_IPG_LENGTH_ADDR    = 32'h0000_005C;
    localparam axil_addr_t PCS_CONTROL_ADDR      = 32'h0000_0200;
    localparam axil_addr_t PCS_STATUS_ADDR       = 32'h0000_0204;
    localparam axil_addr_t LINK_TIMER_0_ADDR     = 32'h0000_0248;
    localparam axil_addr_t LINK_TIMER_1_ADDR     = 32'h0000_024C;
    localparam axil_addr_t IF_MODE_ADDR          = 32'h0000_0250;

    // status and control bits that the polls wait on
    localparam axil_data_t LINK_UP_BIT   = 32'h0000_0004;
    localparam axil_data_t PCS_RESET_BIT = 32'h0000_8000;
    localparam axil_data_t MAC_RESET_BIT = 32'h0000_2000;
    localparam axil_data_t TX_RX_EN_BITS = 32'h0000_0003;

    // 1.6 ms sgmii link timer at 125 MHz
    localparam axil_data_t LINK_TIMER_0_VAL     = 32'h0000_0D40;
    localparam axil_data_t LINK_TIMER_1_VAL     = 32'h0000_0003;
    localparam axil_data_t IF_MODE_VAL          = 32'h0000_0003;
    localparam axil_data_t PCS_CONTROL_INIT     = 32'h0000_1140;
    localparam axil_data_t PCS_RESET_VAL        = PCS_CONTROL_INIT | PCS_RESET_BIT;
    localparam axil_data_t TX_SECTION_EMPTY_VAL = 32'h0000_07F0;
    localparam axil_data_t TX_ALMOST_FULL_VAL   = 32'h0000_0003;
    localparam axil_data_t TX_ALMOST_EMPTY_VAL  = 32'h0000_0008;
    localparam axil_data_t TX_SECTION_FULL_VAL  = 32'h0000_0010;
    localparam axil_data_t RX_SECTION_EMPTY_VAL = 32'h0000_07F0;
    localparam axil_data_t RX_ALMOST_FULL_VAL   = 32'h0000_0008;
    localparam axil_data_t RX_ALMOST_EMPTY_VAL  = 32'h0000_0008;
    localparam axil_data_t RX_SECTION_FULL_VAL  = 32'h0000_0010;
    localparam axil_data_t MAC_0_VAL            = 32'h1723_1C00;
    localparam axil_data_t MAC_1_VAL            = 32'h0000_CB4A;
    localparam axil_data_t FRM_LENGTH_VAL       = 32'h0000_05EE;
    localparam axil_data_t TX_IPG_LENGTH_VAL    = 32'h0000_000C;
    localparam axil_data_t PAUSE_QUANT_VAL      = 32'h0000_FFFF;
    localparam axil_data_t CMD_CFG_DISABLE      = 32'h0080_0220;
    localparam axil_data_t CMD_CFG_RESET        = CMD_CFG_DISABLE | MAC_RESET_BIT;
    localparam axil_data_t CMD_CFG_ENABLE       = CMD_CFG_DISABLE | TX_RX_EN_BITS;

    localparam int INIT_STEPS = 25;

    typedef logic [4:0] init_step_t;

    localparam cmd_kind_t INIT_KIND [INIT_STEPS] = '{
        CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_POLL, CMD_WRITE, CMD_POLL, CMD_WRITE, CMD_POLL,
        CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE,
        CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE, CMD_WRITE,
        CMD_WRITE, CMD_POLL, CMD_WRITE, CMD_POLL};

    localparam axil_addr_t INIT_ADDR [INIT_STEPS] = '{
        LINK_TIMER_0_ADDR, LINK_TIMER_1_ADDR, IF_MODE_ADDR, PCS_STATUS_ADDR,
        PCS_CONTROL_ADDR, PCS_CONTROL_ADDR, COMMAND_CONFIG_ADDR, COMMAND_CONFIG_ADDR,
        TX_SECTION_EMPTY_ADDR, TX_ALMOST_FULL_ADDR, TX_ALMOST_EMPTY_ADDR, TX_SECTION_FULL_ADDR,
        RX_SECTION_EMPTY_ADDR, RX_ALMOST_FULL_ADDR, RX_ALMOST_EMPTY_ADDR, RX_SECTION_FULL_ADDR,
        MAC_0_ADDR, MAC_1_ADDR, FRM_LENGTH_ADDR, TX_IPG_LENGTH_ADDR, PAUSE_QUANT_ADDR,
        COMMAND_CONFIG_ADDR, COMMAND_CONFIG_ADDR, COMMAND_CONFIG_ADDR, COMMAND_CONFIG_ADDR};

    // write value, or the expected masked value of a poll
    localparam axil_data_t INIT_DATA [INIT_STEPS] = '{
        LINK_TIMER_0_VAL, LINK_TIMER_1_VAL, IF_MODE_VAL, LINK_UP_BIT,
        PCS_RESET_VAL, 32'h0, CMD_CFG_DISABLE, 32'h0,
        TX_SECTION_EMPTY_VAL, TX_ALMOST_FULL_VAL, TX_ALMOST_EMPTY_VAL, TX_SECTION_FULL_VAL,
        RX_SECTION_EMPTY_VAL, RX_ALMOST_FULL_VAL, RX_ALMOST_EMPTY_VAL, RX_SECTION_FULL_VAL,
        MAC_0_VAL, MAC_1_VAL, FRM_LENGTH_VAL, TX_IPG_LENGTH_VAL, PAUSE_QUANT_VAL,
        CMD_CFG_RESET, 32'h0, CMD_CFG_ENABLE, TX_RX_EN_BITS};

    localparam axil_data_t INIT_MASK [INIT_STEPS] = '{
        32'h0, 32'h0, 32'h0, LINK_UP_BIT, 32'h0, PCS_RESET_BIT, 32'h0, TX_RX_EN_BITS,
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
        32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
        32'h0, MAC_RESET_BIT, 32'h0, TX_RX_EN_BITS};

endpackage

/* src/mac_init_pkg.sv */
package mac_init_pkg;

    // register bus widths
    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic
    {
        CMD_WRITE = 1'b0,
        CMD_POLL  = 1'b1
    } cmd_kind_t;

    typedef enum logic [1:0]
    {
        S_WAIT_INIT = 2'd0,
        S_ISSUE     = 2'd1,
        S_DONE      = 2'd2
    } seq_state_t;

    // start-up delay before the first register access
    localparam int WAIT_INIT_CYCLES = 64;

    localparam int CMD_FIFO_DEPTH = 4;

endpackage
